// File: hw/exec_defines.svh
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// datapath and address width
`define EXEC_XLEN 32

// link address and not-taken fallthrough, past the delay slot
`define EXEC_LINK_OFFSET 8

`define EXEC_TRUE 1'b1
`define EXEC_FALSE 1'b0

`endif

// File: hw/exec_ops_pkg.sv
package exec_ops_pkg;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_nor  = 4'd5,
        alu_slt  = 4'd6,
        alu_sltu = 4'd7
    } alu_op_e;

    // lez through gez test num1 alone against zero
    typedef enum logic [2:0] {
        cmp_eq  = 3'd0,
        cmp_ne  = 3'd1,
        cmp_lez = 3'd2,
        cmp_gtz = 3'd3,
        cmp_ltz = 3'd4,
        cmp_gez = 3'd5
    } cmp_op_e;

    typedef enum logic [2:0] {
        cls_branch = 3'd0,
        cls_arith  = 3'd1,
        cls_memory = 3'd2,
        cls_shift  = 3'd3,
        cls_none   = 3'd4
    } exe_class_e;

    typedef enum logic [1:0] {
        br_b  = 2'd0,
        br_j  = 2'd1,
        br_jr = 2'd2
    } branch_kind_e;

    // _u variants zero-extend on load
    typedef enum logic [2:0] {
        mem_byte   = 3'd0,
        mem_byte_u = 3'd1,
        mem_half   = 3'd2,
        mem_half_u = 3'd3,
        mem_word   = 3'd4
    } mem_size_e;

endpackage

// File: hw/exec_bus_pkg.sv
`include "exec_defines.svh"

package exec_bus_pkg;

    // decoded instruction with operands, as issued to execute
    typedef struct packed {
        logic [`EXEC_XLEN-1:0]      pc;
        logic [`EXEC_XLEN-1:0]      num1;
        logic [`EXEC_XLEN-1:0]      num2;
        logic [`EXEC_XLEN-1:0]      memory_addr_offset;
        // branch target for b and j, predicted target for jr
        logic [`EXEC_XLEN-1:0]      predict_pc_addr;
        exec_ops_pkg::alu_op_e      alu_op;
        exec_ops_pkg::cmp_op_e      llu_op;
        exec_ops_pkg::exe_class_e   exe_type;
        exec_ops_pkg::branch_kind_e brunch_type;
        logic                       shift_left;
        exec_ops_pkg::mem_size_e    mem_type;
        logic                       mem_read_ena;
        logic                       mem_write_ena;
        logic                       write_reg_need;
        logic [4:0]                 write_reg_addr;
        logic                       predict_brunch_taken;
    } fu_require_t;

    // fetch redirect
    typedef struct packed {
        logic                  enable;
        logic [`EXEC_XLEN-1:0] pc_new;
    } pc_check_t;

    typedef struct packed {
        logic [`EXEC_XLEN-1:0]   result;
        logic [`EXEC_XLEN-1:0]   addr;
        logic [`EXEC_XLEN-1:0]   write_data;
        exec_ops_pkg::mem_size_e mem_type;
        logic                    mem_read_ena;
        logic                    mem_write_ena;
        logic                    write_reg_need;
        logic [4:0]              write_reg_addr;
    } mem_require_t;

endpackage

// File: hw/alu.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module alu (
    input  logic [`EXEC_XLEN-1:0] a,
    input  logic [`EXEC_XLEN-1:0] b,
    input  exec_ops_pkg::alu_op_e alu_op,
    output logic [`EXEC_XLEN-1:0] c
);

    logic slt_signed;
    logic slt_unsigned;

    assign slt_signed   = $signed(a) < $signed(b);
    assign slt_unsigned = a < b;

    always_comb begin
        case (alu_op)
            exec_ops_pkg::alu_add: c = a + b;
            exec_ops_pkg::alu_sub: c = a - b;
            exec_ops_pkg::alu_and: c = a & b;
            exec_ops_pkg::alu_or:  c = a | b;
            exec_ops_pkg::alu_xor: c = a ^ b;
            exec_ops_pkg::alu_nor: c = ~(a | b);
            // compare flag lands in bit 0
            exec_ops_pkg::alu_slt: begin
                c = {{(`EXEC_XLEN-1){1'b0}}, slt_signed};
            end
            exec_ops_pkg::alu_sltu: begin
                c = {{(`EXEC_XLEN-1){1'b0}}, slt_unsigned};
            end
            default: c = '0;
        endcase
    end

endmodule

// File: hw/branch_compare.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module branch_compare (
    input  logic [`EXEC_XLEN-1:0] a,
    input  logic [`EXEC_XLEN-1:0] b,
    input  exec_ops_pkg::cmp_op_e llu_op,
    output logic                  c
);

    logic a_neg;
    logic a_zero;

    // sign and zero of a are enough for the compare-with-zero ops
    assign a_neg  = a[`EXEC_XLEN-1];
    assign a_zero = (a == '0);

    always_comb begin
        case (llu_op)
            exec_ops_pkg::cmp_eq:  c = (a == b);
            exec_ops_pkg::cmp_ne:  c = (a != b);
            exec_ops_pkg::cmp_lez: c = a_neg | a_zero;
            exec_ops_pkg::cmp_gtz: c = ~a_neg & ~a_zero;
            exec_ops_pkg::cmp_ltz: c = a_neg;
            exec_ops_pkg::cmp_gez: c = ~a_neg;
            default:               c = `EXEC_FALSE;
        endcase
    end

endmodule

// File: hw/fu.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module fu (
    input  exec_bus_pkg::fu_require_t  fu_require,
    output exec_bus_pkg::pc_check_t    pc_execute,
    output exec_bus_pkg::mem_require_t mem_require
);

    logic [`EXEC_XLEN-1:0] alu_result;
    logic [`EXEC_XLEN-1:0] shift_result;
    logic [`EXEC_XLEN-1:0] link_addr;
    logic [4:0]            shamt;
    logic                  cond_true;
    logic                  predicted_taken;

    alu i_alu (
        .a      (fu_require.num1),
        .b      (fu_require.num2),
        .alu_op (fu_require.alu_op),
        .c      (alu_result)
    );

    branch_compare i_branch_compare (
        .a      (fu_require.num1),
        .b      (fu_require.num2),
        .llu_op (fu_require.llu_op),
        .c      (cond_true)
    );

    assign link_addr = fu_require.pc + `EXEC_XLEN'(`EXEC_LINK_OFFSET);

    assign shamt = fu_require.num2[4:0];
    assign shift_result = (fu_require.shift_left == `EXEC_TRUE) ?
                          (fu_require.num1 << shamt) :
                          (fu_require.num1 >> shamt);

    assign predicted_taken = (fu_require.predict_brunch_taken == `EXEC_TRUE);

    always_comb begin
        case (fu_require.exe_type)
            exec_ops_pkg::cls_branch: mem_require.result = link_addr;
            exec_ops_pkg::cls_arith:  mem_require.result = alu_result;
            exec_ops_pkg::cls_memory: mem_require.result = alu_result;
            exec_ops_pkg::cls_shift:  mem_require.result = shift_result;
            default:                  mem_require.result = '0;
        endcase
        mem_require.addr           = fu_require.num1 + fu_require.memory_addr_offset;
        mem_require.write_data     = fu_require.num2;
        mem_require.mem_type       = fu_require.mem_type;
        mem_require.mem_read_ena   = fu_require.mem_read_ena;
        mem_require.mem_write_ena  = fu_require.mem_write_ena;
        mem_require.write_reg_need = fu_require.write_reg_need;
        mem_require.write_reg_addr = fu_require.write_reg_addr;
    end

    // prediction check against the resolved outcome
    always_comb begin
        pc_execute.enable = `EXEC_FALSE;
        pc_execute.pc_new = '0;
        if (fu_require.exe_type == exec_ops_pkg::cls_branch) begin
            case (fu_require.brunch_type)
                exec_ops_pkg::br_b: begin
                    if (cond_true && !predicted_taken) begin
                        pc_execute.enable = `EXEC_TRUE;
                        pc_execute.pc_new = fu_require.predict_pc_addr;
                    end else if (!cond_true && predicted_taken) begin
                        // fall through past the delay slot
                        pc_execute.enable = `EXEC_TRUE;
                        pc_execute.pc_new = link_addr;
                    end
                end
                exec_ops_pkg::br_j: begin
                    if (!predicted_taken) begin
                        pc_execute.enable = `EXEC_TRUE;
                        pc_execute.pc_new = fu_require.predict_pc_addr;
                    end
                end
                exec_ops_pkg::br_jr: begin
                    // wrong target counts as a miss too
                    if (!predicted_taken || fu_require.predict_pc_addr != fu_require.num1) begin
                        pc_execute.enable = `EXEC_TRUE;
                        pc_execute.pc_new = fu_require.num1;
                    end
                end
                default: begin
                    pc_execute.enable = `EXEC_FALSE;
                end
            endcase
        end
    end

endmodule

// File: hw/exec_stage.sv
`timescale 1ns/1ps

module exec_stage (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       issue_valid,
    input  exec_bus_pkg::fu_require_t  issue,
    output logic                       mem_valid,
    output exec_bus_pkg::mem_require_t mem_require,
    output exec_bus_pkg::pc_check_t    redirect
);

    exec_bus_pkg::fu_require_t  ex_req;
    logic                       ex_valid;
    exec_bus_pkg::mem_require_t fu_mem;
    exec_bus_pkg::pc_check_t    fu_pc;
    logic                       ex_redirect;

    fu i_fu (
        .fu_require  (ex_req),
        .pc_execute  (fu_pc),
        .mem_require (fu_mem)
    );

    // a live mispredict in execute kills the wrong-path issue behind it
    assign ex_redirect = ex_valid & fu_pc.enable;

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid        <= 1'b0;
            mem_valid       <= 1'b0;
            redirect.enable <= 1'b0;
        end else begin
            ex_valid        <= issue_valid & ~ex_redirect;
            mem_valid       <= ex_valid;
            redirect.enable <= ex_redirect;
        end
    end

    always_ff @(posedge clk) begin
        ex_req          <= issue;
        mem_require     <= fu_mem;
        redirect.pc_new <= fu_pc.pc_new;
    end

    a_squash_behind_redirect: assert property (
        @(posedge clk) disable iff (reset)
        redirect.enable |-> !ex_valid
    ) else $error("exec_stage: wrong-path issue entered execute behind a redirect");

    a_quiet_after_reset: assert property (
        @(posedge clk)
        $past(reset) |-> (!mem_valid && !redirect.enable)
    ) else $error("exec_stage: outputs active right after reset");

endmodule

// File: tb/tb_exec_stage.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module tb_exec_stage;

    typedef exec_bus_pkg::fu_require_t  req_t;
    typedef exec_bus_pkg::mem_require_t mreq_t;
    typedef exec_bus_pkg::pc_check_t    pcc_t;

    localparam int N_RANDOM = 300;
    // directed branches and jumps each followed by a filler, then drain
    localparam int N_CYCLES = 36 * 2 + 5 * 2 + N_RANDOM + 4 + 2;

    logic  clk = 1'b0;
    logic  reset;
    logic  issue_valid;
    req_t  issue;
    logic  mem_valid;
    mreq_t mem_require;
    pcc_t  redirect;

    logic [15:0] lfsr_state;
    int          errors;
    logic [31:0] branch_vals [0:2] = '{32'd0, 32'd7, 32'hffff_fffd};

    // two-deep model pipeline, execute then memory
    logic  m_ex_valid;
    mreq_t m_ex_mem;
    pcc_t  m_ex_pc;
    logic  m_mem_valid;
    mreq_t m_mem;
    logic  m_redir_en;
    logic  [`EXEC_XLEN-1:0] m_redir_pc;

    exec_stage i_dut (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue       (issue),
        .mem_valid   (mem_valid),
        .mem_require (mem_require),
        .redirect    (redirect)
    );

    always #2 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function automatic logic [31:0] take_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] alu_ref(exec_ops_pkg::alu_op_e op, logic [31:0] a,
                                            logic [31:0] b);
        case (op)
            exec_ops_pkg::alu_add:  return a + b;
            exec_ops_pkg::alu_sub:  return a - b;
            exec_ops_pkg::alu_and:  return a & b;
            exec_ops_pkg::alu_or:   return a | b;
            exec_ops_pkg::alu_xor:  return a ^ b;
            exec_ops_pkg::alu_nor:  return ~(a | b);
            exec_ops_pkg::alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            exec_ops_pkg::alu_sltu: return (a < b) ? 32'd1 : 32'd0;
            default:                return 32'd0;
        endcase
    endfunction

    function automatic logic cond_ref(exec_ops_pkg::cmp_op_e op, logic [31:0] a,
                                      logic [31:0] b);
        case (op)
            exec_ops_pkg::cmp_eq:  return a == b;
            exec_ops_pkg::cmp_ne:  return a != b;
            exec_ops_pkg::cmp_lez: return $signed(a) <= 0;
            exec_ops_pkg::cmp_gtz: return $signed(a) > 0;
            exec_ops_pkg::cmp_ltz: return $signed(a) < 0;
            exec_ops_pkg::cmp_gez: return $signed(a) >= 0;
            default:               return 1'b0;
        endcase
    endfunction

    function automatic mreq_t expect_mem(req_t r);
        mreq_t m;
        m.addr           = r.num1 + r.memory_addr_offset;
        m.write_data     = r.num2;
        m.mem_type       = r.mem_type;
        m.mem_read_ena   = r.mem_read_ena;
        m.mem_write_ena  = r.mem_write_ena;
        m.write_reg_need = r.write_reg_need;
        m.write_reg_addr = r.write_reg_addr;
        if (r.exe_type == exec_ops_pkg::cls_branch)
            m.result = r.pc + `EXEC_XLEN'(`EXEC_LINK_OFFSET);
        else if (r.exe_type == exec_ops_pkg::cls_arith || r.exe_type == exec_ops_pkg::cls_memory)
            m.result = alu_ref(r.alu_op, r.num1, r.num2);
        else if (r.exe_type == exec_ops_pkg::cls_shift)
            m.result = r.shift_left ? r.num1 << r.num2[4:0] : r.num1 >> r.num2[4:0];
        else
            m.result = '0;
        return m;
    endfunction

    function automatic pcc_t expect_redirect(req_t r);
        pcc_t p;
        logic taken;
        p = '0;
        taken = cond_ref(r.llu_op, r.num1, r.num2);
        if (r.exe_type == exec_ops_pkg::cls_branch) begin
            if (r.brunch_type == exec_ops_pkg::br_b && taken != r.predict_brunch_taken) begin
                p.enable = 1'b1;
                p.pc_new = taken ? r.predict_pc_addr : r.pc + `EXEC_XLEN'(`EXEC_LINK_OFFSET);
            end else if (r.brunch_type == exec_ops_pkg::br_j && !r.predict_brunch_taken) begin
                p.enable = 1'b1;
                p.pc_new = r.predict_pc_addr;
            end else if (r.brunch_type == exec_ops_pkg::br_jr &&
                         (!r.predict_brunch_taken || r.predict_pc_addr != r.num1)) begin
                p.enable = 1'b1;
                p.pc_new = r.num1;
            end
        end
        return p;
    endfunction

    // write data and control fields carried straight through to memory
    function automatic logic [`EXEC_XLEN+10:0] passthrough_bits(mreq_t m);
        return {m.write_data, m.mem_type, m.mem_read_ena, m.mem_write_ena,
                m.write_reg_need, m.write_reg_addr};
    endfunction

    function automatic req_t random_item();
        req_t r;
        logic [31:0] bits;
        bits = take_bits(30);
        r.pc = {bits[29:0], 2'b00};
        r.num1 = take_bits(32);
        r.num2 = take_bits(32);
        bits = take_bits(2);
        if (bits[1:0] == 2'd0)
            r.num2 = r.num1;
        bits = take_bits(16);
        r.memory_addr_offset = {{16{bits[15]}}, bits[15:0]};
        r.predict_pc_addr = take_bits(32);
        if (take_bits(1) == 32'd1)
            r.predict_pc_addr = r.num1;
        bits = take_bits(3);
        r.alu_op = exec_ops_pkg::alu_op_e'({1'b0, bits[2:0]});
        bits = take_bits(3) % 6;
        r.llu_op = exec_ops_pkg::cmp_op_e'(bits[2:0]);
        bits = take_bits(3) % 5;
        r.exe_type = exec_ops_pkg::exe_class_e'(bits[2:0]);
        bits = take_bits(2) % 3;
        r.brunch_type = exec_ops_pkg::branch_kind_e'(bits[1:0]);
        bits = take_bits(3) % 5;
        r.mem_type = exec_ops_pkg::mem_size_e'(bits[2:0]);
        bits = take_bits(10);
        r.shift_left           = bits[0];
        r.mem_read_ena         = bits[1];
        r.mem_write_ena        = bits[2];
        r.write_reg_need       = bits[3];
        r.write_reg_addr       = bits[8:4];
        r.predict_brunch_taken = bits[9];
        return r;
    endfunction

    function automatic req_t filler_item();
        req_t r;
        r = random_item();
        r.exe_type = exec_ops_pkg::cls_arith;
        return r;
    endfunction

    function automatic req_t branch_item(exec_ops_pkg::cmp_op_e op, logic [31:0] a, logic pred);
        req_t r;
        r = random_item();
        r.exe_type = exec_ops_pkg::cls_branch;
        r.brunch_type = exec_ops_pkg::br_b;
        r.llu_op = op;
        r.num1 = a;
        r.num2 = 32'd7;
        r.predict_brunch_taken = pred;
        return r;
    endfunction

    function automatic req_t jump_item(exec_ops_pkg::branch_kind_e kind, logic pred,
                                       logic match);
        req_t r;
        r = random_item();
        r.exe_type = exec_ops_pkg::cls_branch;
        r.brunch_type = kind;
        r.predict_brunch_taken = pred;
        r.predict_pc_addr = match ? r.num1 : ~r.num1;
        return r;
    endfunction

    task automatic drive(input logic v, input req_t r);
        issue_valid = v;
        issue = r;
        @(posedge clk);
        #1;
    endtask

    always @(posedge clk) begin
        if (reset) begin
            m_ex_valid  <= 1'b0;
            m_mem_valid <= 1'b0;
            m_redir_en  <= 1'b0;
        end else begin
            // squashed when a mispredicting branch sits in execute
            m_ex_valid  <= issue_valid && !(m_ex_valid && m_ex_pc.enable);
            m_ex_mem    <= expect_mem(issue);
            m_ex_pc     <= expect_redirect(issue);
            m_mem_valid <= m_ex_valid;
            m_mem       <= m_ex_mem;
            m_redir_en  <= m_ex_valid && m_ex_pc.enable;
            m_redir_pc  <= m_ex_pc.pc_new;
        end
    end

    a_mem_valid: assert property (@(negedge clk) disable iff (reset)
        mem_valid == m_mem_valid) else begin
        $display("** Error [mem_valid]: expected %0b, actual %0b", m_mem_valid, mem_valid);
        errors = errors + 1;
    end

    a_result: assert property (@(negedge clk) disable iff (reset)
        (mem_valid && m_mem_valid) |-> mem_require.result == m_mem.result) else begin
        $display("** Error [result]: expected %h, actual %h", m_mem.result, mem_require.result);
        errors = errors + 1;
    end

    a_addr: assert property (@(negedge clk) disable iff (reset)
        (mem_valid && m_mem_valid) |-> mem_require.addr == m_mem.addr) else begin
        $display("** Error [addr]: expected %h, actual %h", m_mem.addr, mem_require.addr);
        errors = errors + 1;
    end

    a_passthrough: assert property (@(negedge clk) disable iff (reset)
        (mem_valid && m_mem_valid) |->
        passthrough_bits(mem_require) == passthrough_bits(m_mem)) else begin
        $display("** Error [passthrough]: expected %h, actual %h",
                 passthrough_bits(m_mem), passthrough_bits(mem_require));
        errors = errors + 1;
    end

    a_redirect_en: assert property (@(negedge clk) disable iff (reset)
        redirect.enable == m_redir_en) else begin
        $display("** Error [redirect_en]: expected %0b, actual %0b",
                 m_redir_en, redirect.enable);
        errors = errors + 1;
    end

    a_redirect_pc: assert property (@(negedge clk) disable iff (reset)
        (redirect.enable && m_redir_en) |-> redirect.pc_new == m_redir_pc) else begin
        $display("** Error [redirect_pc]: expected %h, actual %h", m_redir_pc, redirect.pc_new);
        errors = errors + 1;
    end

    initial begin
        #(N_CYCLES * 4 + 100);
        $display("watchdog expired after %0d ns, stimulus did not finish", N_CYCLES * 4 + 100);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        logic [31:0] bits;
        reset = 1'b1;
        issue_valid = 1'b0;
        issue = '0;
        errors = 0;
        lfsr_state = 16'd51572;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        // every compare op against values giving both outcomes, both predictions
        for (int op = 0; op < 6; op++) begin
            for (int v = 0; v < 3; v++) begin
                for (int p = 0; p < 2; p++) begin
                    drive(1'b1, branch_item(exec_ops_pkg::cmp_op_e'(op[2:0]),
                                            branch_vals[v], p[0]));
                    drive(1'b1, filler_item());
                end
            end
        end

        drive(1'b1, jump_item(exec_ops_pkg::br_j, 1'b0, 1'b0));
        drive(1'b1, filler_item());
        drive(1'b1, jump_item(exec_ops_pkg::br_j, 1'b1, 1'b0));
        drive(1'b1, filler_item());
        drive(1'b1, jump_item(exec_ops_pkg::br_jr, 1'b0, 1'b1));
        drive(1'b1, filler_item());
        drive(1'b1, jump_item(exec_ops_pkg::br_jr, 1'b1, 1'b0));
        drive(1'b1, filler_item());
        drive(1'b1, jump_item(exec_ops_pkg::br_jr, 1'b1, 1'b1));
        drive(1'b1, filler_item());

        // random mix with idle gaps
        for (int i = 0; i < N_RANDOM; i++) begin
            bits = take_bits(2);
            drive(bits[1:0] != 2'd0, random_item());
        end
        repeat (4) drive(1'b0, '0);

        $display("summary: %0d errors", errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+hw
hw/exec_ops_pkg.sv
hw/exec_bus_pkg.sv
hw/alu.sv
hw/branch_compare.sv
hw/fu.sv
hw/exec_stage.sv
tb/tb_exec_stage.sv

// File: run.sh
#!/bin/sh
# builds and runs the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_exec_stage -f compile.f -o sim_exec_stage
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_exec_stage > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
    exit 0
else
    echo "pass message not found in $LOG"
    exit 1
fi
